// ==== Bender.yml ====
package:
  name: pinmux

sources:
  # RTL in compile order
  - files:
      - hw/pinmux_pkg.sv
      - hw/reg_blk_decode.sv
      - hw/glbl_reg.sv
      - hw/gpio_reg.sv
      - hw/timer_reg.sv
      - hw/semaphore_reg.sv
      - hw/pinmux_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_pinmux_top.sv

// ==== hw/glbl_reg.sv ====
module glbl_reg (
   input  logic                   mclk,
   input  logic                   s_reset_ssn,
   input  logic                   cs_i,
   input  logic                   wr_i,
   input  pinmux_pkg::word_addr_t word_i,
   input  pinmux_pkg::reg_data_t  wdata_i,
   input  pinmux_pkg::reg_be_t    be_i,
   output pinmux_pkg::reg_data_t  rdata_o,
   output logic                   ack_o,
   input  logic                   gpio_intr_i,
   input  logic                   timer_intr_i,
   output logic                   irq_o,
   output logic                   soft_irq_o
);

   pinmux_pkg::reg_data_t wmask;
   pinmux_pkg::reg_data_t mask_q;
   logic [1:0]            status_q;
   logic [1:0]            status_set;
   logic                  soft_q;
   logic                  wr_en;
   logic                  rd_en;

   // Access strobes, only on the edge that raises ack
   assign wr_en = cs_i & wr_i & ~ack_o;
   assign rd_en = cs_i & ~wr_i & ~ack_o;

   // Byte enables widened to bit lanes
   assign wmask = {{8{be_i[3]}}, {8{be_i[2]}}, {8{be_i[1]}}, {8{be_i[0]}}};

   // Bit 0 GPIO level, bit 1 timer pulse
   assign status_set = {timer_intr_i, gpio_intr_i};

   // ------------------------------------------------------------
   // Control registers
   // ------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_o    <= 1'b0;
         mask_q   <= '0;
         status_q <= '0;
         soft_q   <= 1'b0;
      end else begin
         ack_o <= cs_i & ~ack_o;
         if (wr_en && word_i == pinmux_pkg::GLBL_MASK) begin
            mask_q <= (mask_q & ~wmask) | (wdata_i & wmask);
         end
         // Write one to clear, a new event on the same edge stays set
         if (wr_en && word_i == pinmux_pkg::GLBL_STATUS && be_i[0]) begin
            status_q <= (status_q & ~wdata_i[1:0]) | status_set;
         end else begin
            status_q <= status_q | status_set;
         end
         if (wr_en && word_i == pinmux_pkg::GLBL_SOFT && be_i[0]) begin
            soft_q <= wdata_i[0];
         end
      end
   end

   // Read data
   always_ff @(posedge mclk) begin
      if (rd_en) begin
         case (word_i)
            pinmux_pkg::GLBL_ID:     rdata_o <= pinmux_pkg::CHIP_ID;
            pinmux_pkg::GLBL_MASK:   rdata_o <= mask_q;
            pinmux_pkg::GLBL_STATUS: rdata_o <= {30'd0, status_q};
            pinmux_pkg::GLBL_SOFT:   rdata_o <= {31'd0, soft_q};
            default:                 rdata_o <= '0;
         endcase
      end
   end

   // Only the low mask bits gate interrupts
   assign irq_o      = |(status_q & mask_q[1:0]);
   assign soft_irq_o = soft_q;

endmodule

// ==== hw/gpio_reg.sv ====
module gpio_reg (
   input  logic                   mclk,
   input  logic                   s_reset_ssn,
   input  logic                   cs_i,
   input  logic                   wr_i,
   input  pinmux_pkg::word_addr_t word_i,
   input  pinmux_pkg::reg_data_t  wdata_i,
   input  pinmux_pkg::reg_be_t    be_i,
   output pinmux_pkg::reg_data_t  rdata_o,
   output logic                   ack_o,
   input  pinmux_pkg::gpio_vec_t  gpio_in_i,
   output pinmux_pkg::gpio_vec_t  gpio_out_o,
   output pinmux_pkg::gpio_vec_t  gpio_oen_o,
   output logic                   gpio_intr_o
);

   pinmux_pkg::reg_data_t wmask;
   pinmux_pkg::gpio_vec_t dir_q;
   pinmux_pkg::gpio_vec_t out_q;
   pinmux_pkg::gpio_vec_t int_en_q;
   pinmux_pkg::gpio_vec_t int_stat_q;
   pinmux_pkg::gpio_vec_t in_s1_q;
   pinmux_pkg::gpio_vec_t in_s2_q;
   pinmux_pkg::gpio_vec_t in_d_q;
   pinmux_pkg::gpio_vec_t rise;
   logic                  wr_en;
   logic                  rd_en;

   assign wr_en = cs_i & wr_i & ~ack_o;
   assign rd_en = cs_i & ~wr_i & ~ack_o;
   assign wmask = {{8{be_i[3]}}, {8{be_i[2]}}, {8{be_i[1]}}, {8{be_i[0]}}};

   // Rising edge seen after the synchroniser, enabled pins only
   assign rise = in_s2_q & ~in_d_q & int_en_q;

   // ------------------------------------------------------------
   // Config and interrupt state
   // ------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_o      <= 1'b0;
         dir_q      <= '0;
         out_q      <= '0;
         int_en_q   <= '0;
         int_stat_q <= '0;
         in_s1_q    <= '0;
         in_s2_q    <= '0;
         in_d_q     <= '0;
      end else begin
         ack_o <= cs_i & ~ack_o;
         // Two-flop synchroniser plus edge history
         in_s1_q <= gpio_in_i;
         in_s2_q <= in_s1_q;
         in_d_q  <= in_s2_q;
         if (wr_en && word_i == pinmux_pkg::GPIO_DIR) begin
            dir_q <= (dir_q & ~wmask) | (wdata_i & wmask);
         end
         if (wr_en && word_i == pinmux_pkg::GPIO_OUT) begin
            out_q <= (out_q & ~wmask) | (wdata_i & wmask);
         end
         if (wr_en && word_i == pinmux_pkg::GPIO_INT_EN) begin
            int_en_q <= (int_en_q & ~wmask) | (wdata_i & wmask);
         end
         // Write one clears, a fresh edge wins
         if (wr_en && word_i == pinmux_pkg::GPIO_INT_STAT) begin
            int_stat_q <= (int_stat_q & ~(wdata_i & wmask)) | rise;
         end else begin
            int_stat_q <= int_stat_q | rise;
         end
      end
   end

   always_ff @(posedge mclk) begin
      if (rd_en) begin
         case (word_i)
            pinmux_pkg::GPIO_DIR:      rdata_o <= dir_q;
            pinmux_pkg::GPIO_OUT:      rdata_o <= out_q;
            pinmux_pkg::GPIO_IN:       rdata_o <= in_s2_q;
            pinmux_pkg::GPIO_INT_EN:   rdata_o <= int_en_q;
            pinmux_pkg::GPIO_INT_STAT: rdata_o <= int_stat_q;
            default:                   rdata_o <= '0;
         endcase
      end
   end

   // DIR set means driven, enable is active low
   assign gpio_out_o  = out_q;
   assign gpio_oen_o  = ~dir_q;
   assign gpio_intr_o = |int_stat_q;

endmodule

// ==== hw/pinmux_pkg.sv ====
package pinmux_pkg;

   // ------------------------------------------------------------
   // Register bus types
   // ------------------------------------------------------------
   // Byte address on the register bus
   typedef logic [10:0] reg_addr_t;
   typedef logic [31:0] reg_data_t;
   // One enable per data byte
   typedef logic [3:0]  reg_be_t;
   // Address bits 10:7
   typedef logic [3:0]  blk_sel_t;
   // Address bits 6:2, word inside a block
   typedef logic [4:0]  word_addr_t;

   // One bit per pad
   typedef logic [31:0] gpio_vec_t;
   // One bit per lock, bit 0 never used
   typedef logic [15:0] sema_vec_t;

   // ------------------------------------------------------------
   // Block select codes, all others unmapped
   // ------------------------------------------------------------
   localparam blk_sel_t SEL_GLBL  = 4'd0;
   localparam blk_sel_t SEL_GPIO  = 4'd1;
   localparam blk_sel_t SEL_TIMER = 4'd3;
   localparam blk_sel_t SEL_SEMA  = 4'd4;

   // Global block words
   localparam word_addr_t GLBL_ID     = 5'd0;
   localparam word_addr_t GLBL_MASK   = 5'd1;
   localparam word_addr_t GLBL_STATUS = 5'd2;
   localparam word_addr_t GLBL_SOFT   = 5'd3;

   // GPIO block words
   localparam word_addr_t GPIO_DIR      = 5'd0;
   localparam word_addr_t GPIO_OUT      = 5'd1;
   localparam word_addr_t GPIO_IN       = 5'd2;
   localparam word_addr_t GPIO_INT_EN   = 5'd3;
   localparam word_addr_t GPIO_INT_STAT = 5'd4;

   // Timer block words
   localparam word_addr_t TMR_CFG   = 5'd0;
   localparam word_addr_t TMR_COUNT = 5'd1;

   // Read-only identifier in the global block
   localparam reg_data_t CHIP_ID = 32'h5058_0100;

   // Timer down-counter states
   typedef enum logic {TMR_IDLE, TMR_RUN} timer_state_e;

endpackage

// ==== hw/pinmux_top.sv ====
module pinmux_top #(
   parameter int clk_per_us = 50
) (
   input  logic                  mclk,
   input  logic                  s_reset_ssn,
   input  logic                  reg_cs_i,
   input  logic                  reg_wr_i,
   input  pinmux_pkg::reg_addr_t reg_addr_i,
   input  pinmux_pkg::reg_data_t reg_wdata_i,
   input  pinmux_pkg::reg_be_t   reg_be_i,
   output pinmux_pkg::reg_data_t reg_rdata_o,
   output logic                  reg_ack_o,
   output logic                  irq_o,
   output logic                  soft_irq_o,
   input  pinmux_pkg::gpio_vec_t gpio_in_i,
   output pinmux_pkg::gpio_vec_t gpio_out_o,
   output pinmux_pkg::gpio_vec_t gpio_oen_o
);

   pinmux_pkg::word_addr_t word_addr;
   pinmux_pkg::reg_data_t  glbl_rdata;
   pinmux_pkg::reg_data_t  gpio_rdata;
   pinmux_pkg::reg_data_t  timer_rdata;
   pinmux_pkg::sema_vec_t  sema_rdata;
   logic                   glbl_cs;
   logic                   gpio_cs;
   logic                   timer_cs;
   logic                   sema_cs;
   logic                   glbl_ack;
   logic                   gpio_ack;
   logic                   timer_ack;
   logic                   sema_ack;
   logic                   gpio_intr;
   logic                   timer_intr;

   // Word index shared by all blocks
   assign word_addr = reg_addr_i[6:2];

   // ------------------------------------------------------------
   // Decode and response path
   // ------------------------------------------------------------
   reg_blk_decode u_decode (
      .mclk, .s_reset_ssn, .reg_cs_i, .reg_addr_i,
      .glbl_cs_o (glbl_cs), .gpio_cs_o (gpio_cs), .timer_cs_o (timer_cs), .sema_cs_o (sema_cs),
      .glbl_rdata_i (glbl_rdata), .gpio_rdata_i (gpio_rdata),
      .timer_rdata_i (timer_rdata), .sema_rdata_i (sema_rdata),
      .glbl_ack_i (glbl_ack), .gpio_ack_i (gpio_ack),
      .timer_ack_i (timer_ack), .sema_ack_i (sema_ack),
      .reg_rdata_o, .reg_ack_o
   );

   // ------------------------------------------------------------
   // Peer register blocks
   // ------------------------------------------------------------
   glbl_reg u_glbl (
      .mclk, .s_reset_ssn, .cs_i (glbl_cs), .wr_i (reg_wr_i), .word_i (word_addr),
      .wdata_i (reg_wdata_i), .be_i (reg_be_i), .rdata_o (glbl_rdata), .ack_o (glbl_ack),
      .gpio_intr_i (gpio_intr), .timer_intr_i (timer_intr), .irq_o, .soft_irq_o
   );

   gpio_reg u_gpio (
      .mclk, .s_reset_ssn, .cs_i (gpio_cs), .wr_i (reg_wr_i), .word_i (word_addr),
      .wdata_i (reg_wdata_i), .be_i (reg_be_i), .rdata_o (gpio_rdata), .ack_o (gpio_ack),
      .gpio_in_i, .gpio_out_o, .gpio_oen_o, .gpio_intr_o (gpio_intr)
   );

   timer_reg #(.clk_per_us (clk_per_us)) u_timer (
      .mclk, .s_reset_ssn, .cs_i (timer_cs), .wr_i (reg_wr_i), .word_i (word_addr),
      .wdata_i (reg_wdata_i), .be_i (reg_be_i), .rdata_o (timer_rdata), .ack_o (timer_ack),
      .timer_intr_o (timer_intr)
   );

   // Locks only see the low half word
   semaphore_reg u_sema (
      .mclk, .s_reset_ssn, .cs_i (sema_cs), .wr_i (reg_wr_i), .word_i (word_addr),
      .wdata_i (reg_wdata_i[15:0]), .be_i (reg_be_i[0]),
      .rdata_o (sema_rdata), .ack_o (sema_ack)
   );

endmodule

// ==== hw/reg_blk_decode.sv ====
module reg_blk_decode (
   input  logic                  mclk,
   input  logic                  s_reset_ssn,
   input  logic                  reg_cs_i,
   input  pinmux_pkg::reg_addr_t reg_addr_i,
   output logic                  glbl_cs_o,
   output logic                  gpio_cs_o,
   output logic                  timer_cs_o,
   output logic                  sema_cs_o,
   input  pinmux_pkg::reg_data_t glbl_rdata_i,
   input  pinmux_pkg::reg_data_t gpio_rdata_i,
   input  pinmux_pkg::reg_data_t timer_rdata_i,
   input  pinmux_pkg::sema_vec_t sema_rdata_i,
   input  logic                  glbl_ack_i,
   input  logic                  gpio_ack_i,
   input  logic                  timer_ack_i,
   input  logic                  sema_ack_i,
   output pinmux_pkg::reg_data_t reg_rdata_o,
   output logic                  reg_ack_o
);

   pinmux_pkg::blk_sel_t blk_sel;
   pinmux_pkg::blk_sel_t blk_sel_q;
   logic                 unmapped;
   logic                 unmap_ack_q;

   // Block select straight from the address
   assign blk_sel  = reg_addr_i[10:7];
   assign unmapped = !(blk_sel inside {pinmux_pkg::SEL_GLBL, pinmux_pkg::SEL_GPIO,
                                       pinmux_pkg::SEL_TIMER, pinmux_pkg::SEL_SEMA});

   // Chip select to exactly one block
   assign glbl_cs_o  = reg_cs_i & (blk_sel == pinmux_pkg::SEL_GLBL);
   assign gpio_cs_o  = reg_cs_i & (blk_sel == pinmux_pkg::SEL_GPIO);
   assign timer_cs_o = reg_cs_i & (blk_sel == pinmux_pkg::SEL_TIMER);
   assign sema_cs_o  = reg_cs_i & (blk_sel == pinmux_pkg::SEL_SEMA);

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         blk_sel_q   <= pinmux_pkg::SEL_GLBL;
         unmap_ack_q <= 1'b0;
      end else begin
         // Hold the select for the response path
         if (reg_cs_i) begin
            blk_sel_q <= blk_sel;
         end
         // Local one-cycle ack for holes in the map
         unmap_ack_q <= reg_cs_i & unmapped & ~unmap_ack_q;
      end
   end

   // ------------------------------------------------------------
   // Response mux, unmapped reads return zero
   // ------------------------------------------------------------
   always_comb begin
      reg_rdata_o = '0;
      reg_ack_o   = unmap_ack_q;
      case (blk_sel_q)
         pinmux_pkg::SEL_GLBL:  begin reg_rdata_o = glbl_rdata_i;  reg_ack_o = glbl_ack_i;  end
         pinmux_pkg::SEL_GPIO:  begin reg_rdata_o = gpio_rdata_i;  reg_ack_o = gpio_ack_i;  end
         pinmux_pkg::SEL_TIMER: begin reg_rdata_o = timer_rdata_i; reg_ack_o = timer_ack_i; end
         pinmux_pkg::SEL_SEMA:  begin reg_rdata_o = {16'h0, sema_rdata_i}; reg_ack_o = sema_ack_i; end
         default: ;
      endcase
   end

   // Any ack seen by the master answers a cs from the edge before
   a_ack_needs_cs: assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      $rose(reg_ack_o) |-> $past(reg_cs_i));

endmodule

// ==== hw/semaphore_reg.sv ====
module semaphore_reg (
   input  logic                   mclk,
   input  logic                   s_reset_ssn,
   input  logic                   cs_i,
   input  logic                   wr_i,
   input  pinmux_pkg::word_addr_t word_i,
   input  pinmux_pkg::sema_vec_t  wdata_i,
   input  logic                   be_i,
   output pinmux_pkg::sema_vec_t  rdata_o,
   output logic                   ack_o
);

   pinmux_pkg::sema_vec_t lock_q;
   logic [3:0]            lock_idx;
   logic                  lock_word;
   logic                  wr_en;
   logic                  rd_en;

   assign wr_en = cs_i & wr_i & ~ack_o;
   assign rd_en = cs_i & ~wr_i & ~ack_o;

   // Words 1 to 15 are locks, word 0 is the bitmap
   assign lock_idx  = word_i[3:0];
   assign lock_word = !word_i[4] && (lock_idx != 4'd0);

   // ------------------------------------------------------------
   // Lock bitmap
   // ------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_o  <= 1'b0;
         lock_q <= '0;
      end else begin
         ack_o <= cs_i & ~ack_o;
         // Read takes a free lock
         if (rd_en && lock_word) begin
            lock_q[lock_idx] <= 1'b1;
         end
         // Write bit 0 high releases
         if (wr_en && lock_word && be_i && wdata_i[0]) begin
            lock_q[lock_idx] <= 1'b0;
         end
      end
   end

   // One if this read won the lock
   always_ff @(posedge mclk) begin
      if (rd_en) begin
         if (lock_word) begin
            rdata_o <= {15'd0, ~lock_q[lock_idx]};
         end else begin
            rdata_o <= (word_i == 5'd0) ? lock_q : '0;
         end
      end
   end

   a_lock0_unused: assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      lock_q[0] == 1'b0);

endmodule

// ==== hw/timer_reg.sv ====
module timer_reg #(
   parameter int clk_per_us = 50
) (
   input  logic                   mclk,
   input  logic                   s_reset_ssn,
   input  logic                   cs_i,
   input  logic                   wr_i,
   input  pinmux_pkg::word_addr_t word_i,
   input  pinmux_pkg::reg_data_t  wdata_i,
   input  pinmux_pkg::reg_be_t    be_i,
   output pinmux_pkg::reg_data_t  rdata_o,
   output logic                   ack_o,
   output logic                   timer_intr_o
);

   // Prescaler wide enough for clk_per_us - 1
   localparam int PRESC_W = $clog2(clk_per_us + 1);
   localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(clk_per_us - 1);

   pinmux_pkg::timer_state_e state_q;
   logic [PRESC_W-1:0]       presc_q;
   logic [15:0]              reload_q;
   logic [15:0]              reload_nxt;
   logic [15:0]              count_q;
   logic                     periodic_q;
   logic                     tick;
   logic                     cfg_wr;
   logic                     rd_en;

   assign cfg_wr = cs_i & wr_i & ~ack_o & (word_i == pinmux_pkg::TMR_CFG);
   assign rd_en  = cs_i & ~wr_i & ~ack_o;

   // Reload lives in CFG bits 31:16
   assign reload_nxt = {be_i[3] ? wdata_i[31:24] : reload_q[15:8],
                        be_i[2] ? wdata_i[23:16] : reload_q[7:0]};

   // One tick per microsecond while running
   assign tick = (state_q == pinmux_pkg::TMR_RUN) && (presc_q == PRESC_LAST);

   // ------------------------------------------------------------
   // Down-count FSM
   // ------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_o        <= 1'b0;
         state_q      <= pinmux_pkg::TMR_IDLE;
         presc_q      <= '0;
         reload_q     <= '0;
         count_q      <= '0;
         periodic_q   <= 1'b0;
         timer_intr_o <= 1'b0;
      end else begin
         ack_o        <= cs_i & ~ack_o;
         timer_intr_o <= 1'b0;
         if (cfg_wr) begin
            reload_q <= reload_nxt;
            // Mode byte written, restart or stop
            if (be_i[0]) begin
               periodic_q <= wdata_i[1];
               presc_q    <= '0;
               count_q    <= reload_nxt;
               state_q    <= wdata_i[0] ? pinmux_pkg::TMR_RUN : pinmux_pkg::TMR_IDLE;
            end
         end else begin
            case (state_q)
               pinmux_pkg::TMR_IDLE: presc_q <= '0;
               pinmux_pkg::TMR_RUN: begin
                  presc_q <= tick ? '0 : presc_q + 1'b1;
                  if (tick && count_q <= 16'd1) begin
                     // Expiry, one-shot drops enable
                     timer_intr_o <= 1'b1;
                     count_q      <= periodic_q ? reload_q : 16'd0;
                     if (!periodic_q) begin
                        state_q <= pinmux_pkg::TMR_IDLE;
                     end
                  end else if (tick) begin
                     count_q <= count_q - 1'b1;
                  end
               end
            endcase
         end
      end
   end

   always_ff @(posedge mclk) begin
      if (rd_en) begin
         case (word_i)
            pinmux_pkg::TMR_CFG:
               rdata_o <= {reload_q, 14'd0, periodic_q, state_q == pinmux_pkg::TMR_RUN};
            pinmux_pkg::TMR_COUNT: rdata_o <= {16'd0, count_q};
            default:               rdata_o <= '0;
         endcase
      end
   end

   // Expiry pulse only ever comes out of a running count
   a_intr_in_run: assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      timer_intr_o |-> $past(state_q) == pinmux_pkg::TMR_RUN);

endmodule

// ==== sim.f ====
+incdir+verification
hw/pinmux_pkg.sv
hw/reg_blk_decode.sv
hw/glbl_reg.sv
hw/gpio_reg.sv
hw/timer_reg.sv
hw/semaphore_reg.sv
hw/pinmux_top.sv
verification/tb_pinmux_top.sv

// ==== verification/tb_pinmux_tests.svh ====
`ifndef TB_PINMUX_TESTS_SVH
`define TB_PINMUX_TESTS_SVH

// ------------------------------------------------------------
// Global block
// ------------------------------------------------------------
task automatic test_glbl();
   pinmux_pkg::reg_data_t rd;
   pinmux_pkg::reg_data_t old_mask;
   pinmux_pkg::reg_data_t new_mask;
   pinmux_pkg::reg_data_t exp_mask;
   pinmux_pkg::reg_be_t   be;
   // Idle outputs out of reset
   check("test_glbl", 32'd0, {29'd0, reg_ack, irq, soft_irq});
   check("test_glbl", 32'd0, gpio_out);
   check("test_glbl", 32'hffff_ffff, gpio_oen);
   reg_read(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_ID, rd);
   check("test_glbl", pinmux_pkg::CHIP_ID, rd);
   old_mask = rand_bits(32);
   new_mask = rand_bits(32);
   // Two bytes enabled, two held
   be       = 4'b0101;
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_MASK, old_mask, 4'hf);
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_MASK, new_mask, be);
   // Only enabled bytes take the new word
   exp_mask = old_mask;
   for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
         exp_mask[8*i +: 8] = new_mask[8*i +: 8];
      end
   end
   reg_read(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_MASK, rd);
   check("test_glbl", exp_mask, rd);
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_SOFT, 32'd1, 4'hf);
   check("test_glbl", 32'd1, soft_irq);
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_SOFT, 32'd0, 4'hf);
   check("test_glbl", 32'd0, soft_irq);
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_MASK, 32'd0, 4'hf);
endtask

// Block select 7 is a hole in the map
task automatic test_unmapped();
   pinmux_pkg::reg_data_t rd;
   pinmux_pkg::blk_sel_t  hole;
   hole = 4'd7;
   // Words 0 and 1 alias a register in every mapped block
   reg_write(hole, 5'd0, 32'hffff_ffff, 4'hf);
   reg_write(hole, 5'd1, 32'hffff_ffff, 4'hf);
   // Nonzero data left on the glbl read path
   reg_read(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_ID, rd);
   reg_read(hole, 5'd0, rd);
   check("test_unmapped", 32'd0, rd);
   // MASK cleared by test_glbl, DIR and OUT still at reset
   reg_read(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_MASK, rd);
   check("test_unmapped", 32'd0, rd);
   reg_read(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_DIR, rd);
   check("test_unmapped", 32'd0, rd);
   reg_read(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_OUT, rd);
   check("test_unmapped", 32'd0, rd);
   // Timer must still be idle with reset config
   reg_read(pinmux_pkg::SEL_TIMER, pinmux_pkg::TMR_CFG, rd);
   check("test_unmapped", 32'd0, rd);
endtask

// ------------------------------------------------------------
// GPIO pads and edge interrupts
// ------------------------------------------------------------
task automatic test_gpio();
   pinmux_pkg::reg_data_t rd;
   pinmux_pkg::gpio_vec_t dir;
   pinmux_pkg::gpio_vec_t out;
   pinmux_pkg::gpio_vec_t in_val;
   pinmux_pkg::gpio_vec_t pin_bit;
   dir    = rand_bits(32);
   out    = rand_bits(32);
   in_val = rand_bits(32);
   reg_write(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_DIR, dir, 4'hf);
   reg_write(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_OUT, out, 4'hf);
   check("test_gpio", out, gpio_out);
   check("test_gpio", ~dir, gpio_oen);
   reg_read(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_DIR, rd);
   check("test_gpio", dir, rd);
   // Read samples on the third edge after the pad change
   gpio_in = in_val;
   wait_cycles(1);
   reg_read(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_IN, rd);
   check("test_gpio", in_val, rd);
   // Low first, then a rising edge on one enabled pin
   pin_bit = 32'd1 << rand_bits(5);
   gpio_in = in_val & ~pin_bit;
   wait_cycles(3);
   reg_write(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_INT_EN, pin_bit, 4'hf);
   gpio_in = in_val | pin_bit;
   wait_cycles(3);
   reg_read(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_INT_STAT, rd);
   check("test_gpio", pin_bit, rd);
   check("test_gpio", 32'd0, irq);
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_MASK, 32'd1, 4'hf);
   check("test_gpio", 32'd1, irq);
   // Source first, else the level sets status again
   reg_write(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_INT_STAT, pin_bit, 4'hf);
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_STATUS, 32'd1, 4'hf);
   check("test_gpio", 32'd0, irq);
   reg_read(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_STATUS, rd);
   check("test_gpio", 32'd0, rd);
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_MASK, 32'd0, 4'hf);
   reg_write(pinmux_pkg::SEL_GPIO, pinmux_pkg::GPIO_INT_EN, 32'd0, 4'hf);
endtask

// One-shot expiry window
task automatic test_timer();
   pinmux_pkg::reg_data_t rd;
   int                    t_start;
   reg_read(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_STATUS, rd);
   check("test_timer", 32'd0, rd);
   // Reload in the upper half, enable set, periodic clear
   reg_write(pinmux_pkg::SEL_TIMER, pinmux_pkg::TMR_CFG, {16'(TIMER_RELOAD), 16'h0001}, 4'hf);
   t_start = cycle_cnt;
   // A read samples two edges after it is issued
   wait_cycles(TIMER_RELOAD * CLK_PER_US - 4 - 2);
   reg_read(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_STATUS, rd);
   check("test_timer", 32'd0, rd[1]);
   rd = '0;
   while (!rd[1] && cycle_cnt - t_start + 2 <= TIMER_RELOAD * CLK_PER_US + 8) begin
      reg_read(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_STATUS, rd);
   end
   check("test_timer", 32'd2, rd);
   reg_read(pinmux_pkg::SEL_TIMER, pinmux_pkg::TMR_CFG, rd);
   check("test_timer", 32'd0, rd[0]);
   reg_write(pinmux_pkg::SEL_GLBL, pinmux_pkg::GLBL_STATUS, 32'd2, 4'hf);
endtask

// Lock 5 acquire and release
task automatic test_sema();
   pinmux_pkg::reg_data_t rd;
   reg_read(pinmux_pkg::SEL_SEMA, 5'd5, rd);
   check("test_sema", 32'd1, rd);
   reg_read(pinmux_pkg::SEL_SEMA, 5'd5, rd);
   check("test_sema", 32'd0, rd);
   reg_read(pinmux_pkg::SEL_SEMA, 5'd0, rd);
   check("test_sema", 32'h0000_0020, rd);
   reg_write(pinmux_pkg::SEL_SEMA, 5'd5, 32'd1, 4'hf);
   reg_read(pinmux_pkg::SEL_SEMA, 5'd5, rd);
   check("test_sema", 32'd1, rd);
   reg_write(pinmux_pkg::SEL_SEMA, 5'd5, 32'd1, 4'hf);
   reg_read(pinmux_pkg::SEL_SEMA, 5'd0, rd);
   check("test_sema", 32'd0, rd);
endtask

`endif

// ==== verification/tb_pinmux_top.sv ====
module tb_pinmux_top;

   localparam int CLK_PER_US   = 4;
   localparam int TIMER_RELOAD = 3;
   // Upper bound on reg_read and reg_write calls over all tests
   localparam int BUS_ACCESSES = 50;
   // Reset, three cycles per access, one timer run, explicit waits, doubled
   localparam int TIMEOUT_CYCLES =
      2 * (4 + 3 * BUS_ACCESSES + TIMER_RELOAD * CLK_PER_US + 8 + 20);

   logic                  mclk;
   logic                  s_reset_ssn;
   logic                  reg_cs;
   logic                  reg_wr;
   pinmux_pkg::reg_addr_t reg_addr;
   pinmux_pkg::reg_data_t reg_wdata;
   pinmux_pkg::reg_be_t   reg_be;
   pinmux_pkg::reg_data_t reg_rdata;
   logic                  reg_ack;
   logic                  irq;
   logic                  soft_irq;
   pinmux_pkg::gpio_vec_t gpio_in;
   pinmux_pkg::gpio_vec_t gpio_out;
   pinmux_pkg::gpio_vec_t gpio_oen;
   logic [15:0]           lfsr_q;
   int                    cycle_cnt;

   pinmux_top #(.clk_per_us (CLK_PER_US)) i_pinmux_top (
      .mclk, .s_reset_ssn, .reg_cs_i (reg_cs), .reg_wr_i (reg_wr), .reg_addr_i (reg_addr),
      .reg_wdata_i (reg_wdata), .reg_be_i (reg_be), .reg_rdata_o (reg_rdata),
      .reg_ack_o (reg_ack), .irq_o (irq), .soft_irq_o (soft_irq), .gpio_in_i (gpio_in),
      .gpio_out_o (gpio_out), .gpio_oen_o (gpio_oen)
   );

   initial begin
      mclk = 1'b0;
      forever #20 mclk = ~mclk;
   end

   // Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
   endfunction

   // One LFSR step per bit drawn
   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         value  = {value[30:0], lfsr_q[0]};
      end
      return value;
   endfunction

   task automatic check(input string test, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("error %s: expected %h, actual %h", test, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "%s mismatch", test);
      end
   endtask

   // ------------------------------------------------------------
   // Register bus master
   // ------------------------------------------------------------
   function automatic pinmux_pkg::reg_addr_t bus_addr(input pinmux_pkg::blk_sel_t sel,
                                                      input pinmux_pkg::word_addr_t word);
      return {sel, word, 2'b00};
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge mclk);
   endtask

   // Hold the request until ack, then drop cs
   task automatic finish_access(output pinmux_pkg::reg_data_t data);
      do begin
         @(negedge mclk);
      end while (!reg_ack);
      data   = reg_rdata;
      reg_cs = 1'b0;
      reg_wr = 1'b0;
   endtask

   task automatic reg_write(input pinmux_pkg::blk_sel_t sel, input pinmux_pkg::word_addr_t word,
                            input pinmux_pkg::reg_data_t data, input pinmux_pkg::reg_be_t be);
      pinmux_pkg::reg_data_t rsp;
      @(negedge mclk);
      reg_cs    = 1'b1;
      reg_wr    = 1'b1;
      reg_addr  = bus_addr(sel, word);
      reg_wdata = data;
      reg_be    = be;
      finish_access(rsp);
   endtask

   task automatic reg_read(input pinmux_pkg::blk_sel_t sel, input pinmux_pkg::word_addr_t word,
                           output pinmux_pkg::reg_data_t data);
      @(negedge mclk);
      reg_cs   = 1'b1;
      reg_wr   = 1'b0;
      reg_addr = bus_addr(sel, word);
      reg_be   = 4'hf;
      finish_access(data);
   endtask

   `include "tb_pinmux_tests.svh"

   // Run limit
   always @(posedge mclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation finished: FAIL");
         $fatal(1, "timeout");
      end
   end

   initial begin
      s_reset_ssn = 1'b0;
      reg_cs      = 1'b0;
      reg_wr      = 1'b0;
      reg_addr    = '0;
      reg_wdata   = '0;
      reg_be      = '0;
      gpio_in     = '0;
      lfsr_q      = 16'd25;
      cycle_cnt   = 0;
      repeat (4) @(negedge mclk);
      s_reset_ssn = 1'b1;
      test_glbl();
      test_unmapped();
      test_gpio();
      test_timer();
      test_sema();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
